// ==== tx_diagram.f ====
+incdir+include
source/tx_diagram_pkg.sv
source/draw_if.sv
source/origin_capture.sv
source/step_sequencer.sv
source/rect_rasterizer.sv
source/plot_writer.sv
source/tx_diagram_top.sv
sim/tb_tx_diagram.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tx_diagram testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 \
	--top-module tb_tx_diagram \
	-f tx_diagram.f \
	--Mdir obj_dir \
	-o tb_tx_diagram
if [ $? -ne 0 ]; then
	echo "run_sim: verilator build failed"
	exit 1
fi

./obj_dir/tb_tx_diagram > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "run_sim: simulation exited with status $status"
	exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
	echo "run_sim: simulation passed"
	exit 0
fi

echo "run_sim: simulation failed, see $LOG"
exit 1

// ==== sim/tb_tx_diagram.sv ====
`timescale 1ns/1ps
`include "tx_diagram_settings.svh"

module tb_tx_diagram;
	import tx_diagram_pkg::*;

	localparam int CYCLE_LIMIT   = 8 * 1900; // eight drawings with slack
	localparam int FULL_PIXELS   = ((`STEP_COUNT + 1) / 2) * `CONN_WIDTH * `CONN_HEIGHT
		+ (`STEP_COUNT / 2) * `PROC_WIDTH * `PROC_HEIGHT;
	localparam int DIAGRAM_WIDTH = (`STEP_COUNT - 1) * `STEP_PITCH + `CONN_WIDTH;

	logic      clk;
	logic      resetn;
	screen_x_t start_x;
	screen_y_t start_y;
	logic      enable;
	logic      plot;
	screen_x_t x_coord;
	screen_y_t y_coord;
	colour_t   colour;
	logic      busy;
	logic      done_drawing;
	logic      rejected;

	logic [19:0] expected[$]; // {x, y, colour} in plot order
	logic        final_visible; // last pixel of the diagram lands on screen
	logic        final_plotted;
	logic        monitor_on;
	logic        in_drawing;
	int          seed;
	int          cycles;
	int          errors;
	int          plot_count;
	int          done_count;
	int          reject_count;
	int          tests_run;
	int          tests_failed;

	tx_diagram_top i_dut (
		.clk          (clk),
		.resetn       (resetn),
		.start_x      (start_x),
		.start_y      (start_y),
		.enable       (enable),
		.plot         (plot),
		.x_coord      (x_coord),
		.y_coord      (y_coord),
		.colour       (colour),
		.busy         (busy),
		.done_drawing (done_drawing),
		.rejected     (rejected)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic report_error(input string msg);
		errors++;
		$display("error %0t: %s", $time, msg);
	endtask

	// expected pixel list, row by row per shape, clipped to the screen
	task automatic build_expected(input int ox, input int oy);
		int      s;
		int      r;
		int      c;
		int      cx;
		int      cy;
		int      w;
		int      h;
		int      px;
		int      py;
		colour_t rgb;
		logic    visible;
		expected.delete();
		final_visible = 1'b0;
		for (s = 0; s < `STEP_COUNT; s++) begin
			cx = ox + s * `STEP_PITCH;
			if (s % 2 == 0) begin
				cy  = oy; // bar
				w   = `CONN_WIDTH;
				h   = `CONN_HEIGHT;
				rgb = `CONN_COLOUR;
			end else begin
				cy  = oy - `PROC_RISE; // raised block
				w   = `PROC_WIDTH;
				h   = `PROC_HEIGHT;
				rgb = `PROC_COLOUR;
			end
			for (r = 0; r < h; r++) begin
				for (c = 0; c < w; c++) begin
					px      = cx + c;
					py      = cy + r;
					visible = (px < `SCREEN_WIDTH) && (py >= 0) && (py < `SCREEN_HEIGHT);
					if (visible) begin
						expected.push_back({screen_x_t'(px), screen_y_t'(py), rgb});
					end
					final_visible = visible;
				end
			end
		end
	endtask

	// plot outputs against the model, sampled where they are stable
	always @(posedge clk) begin
		logic [19:0] want;
		if (monitor_on && resetn) begin
			if (final_plotted) begin
				assert (done_drawing)
					else report_error("done_drawing missing one cycle after the final plot");
				final_plotted = 1'b0;
			end
			if (plot) begin
				plot_count++;
				assert (busy) else report_error("plot while not busy");
				assert (expected.size() > 0)
					else report_error($sformatf("unexpected plot at (%0d,%0d)", x_coord, y_coord));
				if (expected.size() > 0) begin
					want = expected.pop_front();
					assert ({x_coord, y_coord, colour} == want)
						else report_error($sformatf("plot (%0d,%0d) colour %0d, expected (%0d,%0d) colour %0d",
							x_coord, y_coord, colour, want[19:11], want[10:3], want[2:0]));
					if (expected.size() == 0 && final_visible) begin
						final_plotted = 1'b1;
					end
				end
			end
			if (done_drawing) begin
				done_count++;
				assert (expected.size() == 0)
					else report_error($sformatf("done_drawing with %0d pixels missing",
						expected.size()));
				in_drawing = 1'b0;
			end else if (in_drawing) begin
				assert (busy) else report_error("busy low during a drawing");
			end
			if (rejected) begin
				reject_count++;
			end
		end
	end

	task automatic apply_reset();
		resetn = 1'b0;
		repeat (4) @(negedge clk);
		resetn = 1'b1;
	endtask

	task automatic pulse_enable(input int ox, input int oy);
		@(negedge clk);
		start_x = screen_x_t'(ox);
		start_y = screen_y_t'(oy);
		enable  = 1'b1;
		@(negedge clk);
		enable  = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	// poke_after > 0 sends a second enable that many cycles into the drawing
	task automatic run_drawing(input string name, input int ox, input int oy,
			input int poke_after, input int want_pixels);
		int errors_before;
		int done_before;
		int plots_before;
		int rejects_before;
		errors_before  = errors;
		done_before    = done_count;
		plots_before   = plot_count;
		rejects_before = reject_count;
		build_expected(ox, oy);
		pulse_enable(ox, oy);
		in_drawing = 1'b1;
		if (poke_after > 0) begin
			repeat (poke_after) @(negedge clk);
			pulse_enable(10, 20); // on screen but busy
		end
		while (done_count == done_before) @(negedge clk);
		repeat (8) @(negedge clk); // room for a stray second drawing
		assert (done_count == done_before + 1) else report_error("done_drawing count wrong");
		assert (reject_count == rejects_before) else report_error("rejected pulsed on a drawing");
		if (want_pixels >= 0) begin
			assert (plot_count - plots_before == want_pixels)
				else report_error($sformatf("%0d pixels plotted, expected %0d",
					plot_count - plots_before, want_pixels));
		end
		finish_test(name, errors_before);
	endtask

	task automatic check_rejected(input string name, input int ox, input int oy);
		int errors_before;
		int rejects_before;
		errors_before  = errors;
		rejects_before = reject_count;
		expected.delete(); // any plot is an error now
		final_visible = 1'b0;
		pulse_enable(ox, oy);
		repeat (10) begin
			@(negedge clk);
			assert (!busy) else report_error("busy set by an off-screen origin");
		end
		assert (reject_count == rejects_before + 1) else report_error("no single rejected pulse");
		finish_test(name, errors_before);
	endtask

	task automatic reset_mid_drawing(input string name);
		int errors_before;
		errors_before = errors;
		build_expected(40, 100);
		pulse_enable(40, 100);
		in_drawing = 1'b1;
		repeat (200) @(negedge clk);
		monitor_on = 1'b0;
		apply_reset();
		assert (!plot && !busy && !done_drawing) else report_error("outputs not cleared by reset");
		expected.delete();
		in_drawing    = 1'b0;
		final_plotted = 1'b0;
		monitor_on    = 1'b1;
		finish_test(name, errors_before);
	endtask

	initial begin
		int ox;
		int oy;
		int i;
		resetn        = 1'b0;
		enable        = 1'b0;
		start_x       = '0;
		start_y       = '0;
		seed          = 27;
		errors        = 0;
		plot_count    = 0;
		done_count    = 0;
		reject_count  = 0;
		tests_run     = 0;
		tests_failed  = 0;
		monitor_on    = 1'b0;
		in_drawing    = 1'b0;
		final_plotted = 1'b0;
		final_visible = 1'b0;
		apply_reset();
		assert (!plot && !busy && !done_drawing && !rejected)
			else report_error("control outputs not low after reset");
		monitor_on = 1'b1;

		run_drawing("full drawing at (40,100)", 40, 100, 0, FULL_PIXELS);
		for (i = 0; i < 3; i++) begin
			ox = $unsigned($random(seed)) % (`SCREEN_WIDTH - DIAGRAM_WIDTH + 1);
			oy = `PROC_RISE + $unsigned($random(seed)) % (`SCREEN_HEIGHT - `PROC_HEIGHT + 1);
			run_drawing($sformatf("random origin (%0d,%0d)", ox, oy), ox, oy, 0, FULL_PIXELS);
		end
		run_drawing("clipped at right edge", 250, 100, 0, -1);
		run_drawing("clipped at top", 100, 3, 0, -1);
		run_drawing("enable while busy", 40, 100, 500, FULL_PIXELS);
		check_rejected("off-screen x", 330, 100);
		check_rejected("off-screen y", 100, 245);
		reset_mid_drawing("reset mid-drawing");
		run_drawing("drawing after reset", 60, 50, 0, FULL_PIXELS);

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== source/tx_diagram_top.sv ====
`timescale 1ns/1ps

module tx_diagram_top (
	input  logic                      clk,
	input  logic                      resetn,
	input  tx_diagram_pkg::screen_x_t start_x,
	input  tx_diagram_pkg::screen_y_t start_y,
	input  logic                      enable,
	output logic                      plot,
	output tx_diagram_pkg::screen_x_t x_coord,
	output tx_diagram_pkg::screen_y_t y_coord,
	output tx_diagram_pkg::colour_t   colour,
	output logic                      busy,
	output logic                      done_drawing,
	output logic                      rejected
);
	import tx_diagram_pkg::*;

	logic    launch;
	logic    finished;
	wide_x_t origin_x;
	wide_y_t origin_y;

	shape_if shape_bus ();
	pixel_if pixel_bus ();

	origin_capture i_origin_capture (
		.clk      (clk),
		.resetn   (resetn),
		.start_x  (start_x),
		.start_y  (start_y),
		.enable   (enable),
		.finished (finished),
		.launch   (launch),
		.origin_x (origin_x),
		.origin_y (origin_y),
		.busy     (busy),
		.rejected (rejected)
	);

	step_sequencer i_step_sequencer (
		.clk      (clk),
		.resetn   (resetn),
		.launch   (launch),
		.origin_x (origin_x),
		.origin_y (origin_y),
		.finished (finished),
		.sh       (shape_bus.issuer)
	);

	rect_rasterizer i_rect_rasterizer (
		.clk    (clk),
		.resetn (resetn),
		.sh     (shape_bus.drawer),
		.px     (pixel_bus.source)
	);

	plot_writer i_plot_writer (
		.clk          (clk),
		.resetn       (resetn),
		.px           (pixel_bus.sink),
		.plot         (plot),
		.x_coord      (x_coord),
		.y_coord      (y_coord),
		.colour       (colour),
		.done_drawing (done_drawing)
	);

endmodule

// ==== source/plot_writer.sv ====
`timescale 1ns/1ps
`include "tx_diagram_settings.svh"

module plot_writer (
	input  logic                      clk,
	input  logic                      resetn,
	pixel_if.sink                     px,
	output logic                      plot,
	output tx_diagram_pkg::screen_x_t x_coord,
	output tx_diagram_pkg::screen_y_t y_coord,
	output tx_diagram_pkg::colour_t   colour,
	output logic                      done_drawing
);
	import tx_diagram_pkg::*;

	logic x_ok;
	logic y_ok;
	logic accept;
	logic last_q;

	assign x_ok   = (px.x < `SCREEN_WIDTH);
	assign y_ok   = (px.y >= 0) && (px.y < `SCREEN_HEIGHT); // signed compare
	assign accept = px.valid && x_ok && y_ok;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			plot         <= 1'b0;
			last_q       <= 1'b0;
			done_drawing <= 1'b0;
		end else begin
			plot         <= accept;
			last_q       <= px.valid && px.last; // counts even when clipped
			done_drawing <= last_q;
		end
	end

	// narrowing is safe once the pixel passed the clip
	always_ff @(posedge clk) begin
		if (accept) begin
			x_coord <= screen_x_t'(px.x);
			y_coord <= screen_y_t'(px.y);
			colour  <= px.colour;
		end
	end

endmodule

// ==== source/rect_rasterizer.sv ====
`timescale 1ns/1ps

module rect_rasterizer (
	input  logic    clk,
	input  logic    resetn,
	shape_if.drawer sh,
	pixel_if.source px
);
	import tx_diagram_pkg::*;

	logic       active;
	shape_dim_t off_x;  // column within the row
	shape_dim_t off_y;  // row within the rectangle
	wide_x_t    base_x;
	wide_y_t    base_y;
	shape_dim_t width_q;
	shape_dim_t height_q;
	colour_t    colour_q;
	logic       final_q;
	logic       row_end;
	logic       last_pixel;

	assign row_end    = (off_x == width_q - shape_dim_t'(1));
	assign last_pixel = active && row_end && (off_y == height_q - shape_dim_t'(1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			off_x  <= '0;
			off_y  <= '0;
		end else if (sh.start) begin
			active <= 1'b1;
			off_x  <= '0;
			off_y  <= '0;
		end else if (active) begin
			if (row_end) begin
				off_x <= '0;
				if (last_pixel) begin
					active <= 1'b0; // rectangle complete
				end else begin
					off_y <= off_y + shape_dim_t'(1);
				end
			end else begin
				off_x <= off_x + shape_dim_t'(1);
			end
		end
	end

	// request latched on start
	always_ff @(posedge clk) begin
		if (sh.start) begin
			base_x   <= sh.corner_x;
			base_y   <= sh.corner_y;
			width_q  <= sh.width;
			height_q <= sh.height;
			colour_q <= sh.colour;
			final_q  <= sh.final_shape;
		end
	end

	assign sh.done   = last_pixel;
	assign px.valid  = active;
	assign px.x      = base_x + wide_x_t'(off_x);
	assign px.y      = base_y + wide_y_t'({3'b000, off_y}); // offset is never negative
	assign px.colour = colour_q;
	assign px.last   = last_pixel && final_q;

endmodule

// ==== source/step_sequencer.sv ====
`timescale 1ns/1ps
`include "tx_diagram_settings.svh"

module step_sequencer (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    launch,
	input  tx_diagram_pkg::wide_x_t origin_x,
	input  tx_diagram_pkg::wide_y_t origin_y,
	output logic                    finished,
	shape_if.issuer                 sh
);
	import tx_diagram_pkg::*;

	step_t       step;
	shape_kind_t kind;
	logic        running;
	logic        last_step;

	assign last_step = (step == step_t'(`STEP_COUNT - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			step     <= '0;
			kind     <= SHAPE_CONNECTION;
			running  <= 1'b0;
			sh.start <= 1'b0;
			finished <= 1'b0;
		end else begin
			sh.start <= 1'b0;
			finished <= 1'b0;
			if (launch) begin
				step     <= '0;
				kind     <= SHAPE_CONNECTION; // even steps are bars
				running  <= 1'b1;
				sh.start <= 1'b1;
			end else if (running && sh.done) begin
				if (last_step) begin
					running  <= 1'b0;
					finished <= 1'b1;
				end else begin
					step     <= step + step_t'(1);
					kind     <= (kind == SHAPE_CONNECTION) ? SHAPE_PROCESS : SHAPE_CONNECTION;
					sh.start <= 1'b1; // next shape one cycle after done
				end
			end
		end
	end

	// request fields follow the current step, latched by the rasterizer on start
	always_comb begin
		sh.corner_x    = origin_x + wide_x_t'(step * `STEP_PITCH);
		sh.final_shape = last_step;
		if (kind == SHAPE_PROCESS) begin
			sh.corner_y = origin_y - wide_y_t'(`PROC_RISE);
			sh.width    = shape_dim_t'(`PROC_WIDTH);
			sh.height   = shape_dim_t'(`PROC_HEIGHT);
			sh.colour   = `PROC_COLOUR;
		end else begin
			sh.corner_y = origin_y;
			sh.width    = shape_dim_t'(`CONN_WIDTH);
			sh.height   = shape_dim_t'(`CONN_HEIGHT);
			sh.colour   = `CONN_COLOUR;
		end
	end

endmodule

// ==== source/origin_capture.sv ====
`timescale 1ns/1ps
`include "tx_diagram_settings.svh"

module origin_capture (
	input  logic                      clk,
	input  logic                      resetn,
	input  tx_diagram_pkg::screen_x_t start_x,
	input  tx_diagram_pkg::screen_y_t start_y,
	input  logic                      enable,
	input  logic                      finished,
	output logic                      launch,
	output tx_diagram_pkg::wide_x_t   origin_x,
	output tx_diagram_pkg::wide_y_t   origin_y,
	output logic                      busy,
	output logic                      rejected
);
	import tx_diagram_pkg::*;

	logic on_screen;
	logic accept;

	assign on_screen = (start_x < `SCREEN_WIDTH) && (start_y < `SCREEN_HEIGHT);
	assign accept    = enable && !busy && on_screen;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			launch   <= 1'b0;
			busy     <= 1'b0;
			rejected <= 1'b0;
		end else begin
			launch   <= accept;
			rejected <= enable && !busy && !on_screen; // off-screen request
			if (finished) begin
				busy <= 1'b0; // sequencer is through
			end else if (accept) begin
				busy <= 1'b1;
			end
		end
	end

	// origin held for the whole drawing
	always_ff @(posedge clk) begin
		if (accept) begin
			origin_x <= wide_x_t'({1'b0, start_x});
			origin_y <= wide_y_t'({1'b0, start_y}); // always positive
		end
	end

endmodule

// ==== source/draw_if.sv ====
`timescale 1ns/1ps

// rectangle request from the sequencer to the rasterizer
interface shape_if;
	import tx_diagram_pkg::*;

	logic       start;       // one-cycle strobe, rasterizer idle
	wide_x_t    corner_x;
	wide_y_t    corner_y;
	shape_dim_t width;
	shape_dim_t height;
	colour_t    colour;
	logic       final_shape; // last shape of the diagram
	logic       done;        // strobe on the last pixel

	modport issuer (output start, corner_x, corner_y, width, height, colour, final_shape,
		input done);
	modport drawer (input start, corner_x, corner_y, width, height, colour, final_shape,
		output done);
endinterface

// pixel stream, one pixel per valid cycle, no back-pressure
interface pixel_if;
	import tx_diagram_pkg::*;

	logic    valid;
	wide_x_t x;
	wide_y_t y;
	colour_t colour;
	logic    last; // final pixel of the whole diagram

	modport source (output valid, x, y, colour, last);
	modport sink (input valid, x, y, colour, last);
endinterface

// ==== source/tx_diagram_pkg.sv ====
package tx_diagram_pkg;

	// internal x, one bit wider than the screen so sums never wrap
	typedef logic [9:0] wide_x_t;

	// internal y, signed so the block raise can go above row 0
	typedef logic signed [8:0] wide_y_t;

	// screen coordinates, 0..319 and 0..239
	typedef logic [8:0] screen_x_t;
	typedef logic [7:0] screen_y_t;

	typedef logic [2:0] colour_t; // rgb

	// rectangle width or height, up to 32
	typedef logic [5:0] shape_dim_t;

	typedef logic [2:0] step_t; // step index 0..6

	// alternating shapes of the diagram
	typedef enum logic {
		SHAPE_CONNECTION = 1'b0, // flat bar
		SHAPE_PROCESS    = 1'b1  // tall block
	} shape_kind_t;

endpackage

// ==== include/tx_diagram_settings.svh ====
`ifndef TX_DIAGRAM_SETTINGS_SVH
`define TX_DIAGRAM_SETTINGS_SVH

// plotter area
`define SCREEN_WIDTH  320
`define SCREEN_HEIGHT 240

// connection bar
`define CONN_WIDTH  32
`define CONN_HEIGHT 2

// process block
`define PROC_WIDTH  16
`define PROC_HEIGHT 32
`define PROC_RISE   8   // rows above the bars

// layout of the row
`define STEP_PITCH 16
`define STEP_COUNT 7

// rgb colours
`define CONN_COLOUR 3'b010
`define PROC_COLOUR 3'b110

`endif
